// File: design/drp_pkg.sv
package drp_pkg;

    ////////////////////////////////////////
    // port count and bus widths
    ////////////////////////////////////////

    localparam int NUM_SI   = 3;                  // slave ports, 0 has top priority
    localparam int ADDR_W   = 12;                 // DRP address width
    localparam int DATA_W   = 16;                 // DRP data width
    localparam int SI_IDX_W = 2;                  // wide enough for NUM_SI

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    // register address on the DRP bus
    typedef logic [ADDR_W-1:0] drp_addr_t;

    // one DRP data word, read or write
    typedef logic [DATA_W-1:0] drp_data_t;

    // index of a slave port
    typedef logic [SI_IDX_W-1:0] si_idx_t;

    ////////////////////////////////////////
    // arbiter FSM
    ////////////////////////////////////////

    // IDLE  -> pick lowest pending port
    // ISSUE -> drive the master port for one cycle
    // WAIT  -> hold until target ready
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_ISSUE = 2'd1,
        ARB_WAIT  = 2'd2
    } arb_state_t;

endpackage

// File: design/drp_req_if.sv
interface drp_req_if
    import drp_pkg::*;
();

    // slot -> arbiter
    logic      pending;
    logic      we;
    drp_addr_t addr;
    drp_data_t data;

    // arbiter -> slot, single-cycle
    logic      fetch;

    modport slot (
        output pending,
        output we,
        output addr,
        output data,
        input  fetch
    );

    modport arbiter (
        input  pending,
        input  we,
        input  addr,
        input  data,
        output fetch
    );

endinterface

// File: design/drp_req_slot.sv
module drp_req_slot
    import drp_pkg::*;
(
    input  logic      drp_clk_i,
    input  logic      drp_resetn_i,

    // DRP master side of this port
    input  logic      drpen_i,
    input  logic      drpwe_i,
    input  drp_addr_t drpaddr_i,
    input  drp_data_t drpdi_i,

    // captured request towards the arbiter
    drp_req_if.slot   req
);

    logic      pending_q;
    logic      we_q;
    drp_addr_t addr_q;
    drp_data_t data_q;

    ////////////////////////////////////////
    // pending flag
    ////////////////////////////////////////

    // new enable beats a fetch on the same edge
    always_ff @(posedge drp_clk_i) begin
        if (!drp_resetn_i) begin
            pending_q <= 1'b0;
        end else if (drpen_i) begin
            pending_q <= 1'b1;
        end else if (req.fetch) begin
            pending_q <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // request payload
    ////////////////////////////////////////

    always_ff @(posedge drp_clk_i) begin
        if (drpen_i) begin
            we_q   <= drpwe_i;
            addr_q <= drpaddr_i;
            data_q <= drpdi_i;                    // only meaningful on writes
        end
    end

    assign req.pending = pending_q;
    assign req.we      = we_q;
    assign req.addr    = addr_q;
    assign req.data    = data_q;

endmodule

// File: design/drp_arbiter.sv
module drp_arbiter
    import drp_pkg::*;
(
    input  logic                    drp_clk_i,
    input  logic                    drp_resetn_i,

    // captured requests, one per slave port
    drp_req_if.arbiter              req [NUM_SI],

    // master port towards the DRP target
    output logic                    m_drpen_o,
    output logic                    m_drpwe_o,
    output drp_addr_t               m_drpaddr_o,
    output drp_data_t               m_drpdi_o,
    input  logic                    m_drprdy_i,
    input  drp_data_t               m_drpdo_i,

    // responses back to the slave ports
    output logic       [NUM_SI-1:0] s_drprdy_o,
    output drp_data_t  [NUM_SI-1:0] s_drpdo_o
);

    arb_state_t        state_q;
    si_idx_t           grant_q;
    si_idx_t           pick;
    logic              any_pend;

    logic [NUM_SI-1:0] pend_vec;
    logic [NUM_SI-1:0] we_vec;
    drp_addr_t         addr_vec [NUM_SI];
    drp_data_t         data_vec [NUM_SI];

    logic [NUM_SI-1:0] fetch_q;
    logic              m_en_q;
    logic              m_we_q;
    drp_addr_t         m_addr_q;
    drp_data_t         m_data_q;

    ////////////////////////////////////////
    // per-port gather and response routing
    ////////////////////////////////////////

    for (genvar g = 0; g < NUM_SI; g++) begin : g_port
        logic sel;

        assign pend_vec[g]  = req[g].pending;
        assign we_vec[g]    = req[g].we;
        assign addr_vec[g]  = req[g].addr;
        assign data_vec[g]  = req[g].data;
        assign req[g].fetch = fetch_q[g];

        // granted and waiting on the target
        assign sel = (state_q == ARB_WAIT) && (grant_q == si_idx_t'(g));

        assign s_drprdy_o[g] = sel & m_drprdy_i;
        assign s_drpdo_o[g]  = sel ? m_drpdo_i : '0;   // others see zero
    end

    // fixed priority, lowest index wins
    always_comb begin
        any_pend = |pend_vec;
        pick     = '0;
        for (int i = NUM_SI - 1; i >= 0; i--) begin
            if (pend_vec[i]) begin
                pick = si_idx_t'(i);
            end
        end
    end

    ////////////////////////////////////////
    // grant FSM
    ////////////////////////////////////////

    always_ff @(posedge drp_clk_i) begin
        if (!drp_resetn_i) begin
            state_q <= ARB_IDLE;
            grant_q <= '0;
            fetch_q <= '0;
            m_en_q  <= 1'b0;
            m_we_q  <= 1'b0;
        end else begin
            // single-cycle pulses by default
            fetch_q <= '0;
            m_en_q  <= 1'b0;
            m_we_q  <= 1'b0;

            case (state_q)
                ARB_IDLE: begin
                    if (any_pend) begin
                        grant_q <= pick;
                        state_q <= ARB_ISSUE;
                    end
                end

                ARB_ISSUE: begin
                    m_en_q           <= 1'b1;
                    m_we_q           <= we_vec[grant_q];
                    fetch_q[grant_q] <= 1'b1;          // slot drops pending next edge
                    state_q          <= ARB_WAIT;
                end

                ARB_WAIT: begin
                    if (m_drprdy_i) begin
                        state_q <= ARB_IDLE;
                    end
                end

                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // master payload
    ////////////////////////////////////////

    // zero outside the issue cycle
    always_ff @(posedge drp_clk_i) begin
        if (state_q == ARB_ISSUE) begin
            m_addr_q <= addr_vec[grant_q];
            m_data_q <= data_vec[grant_q];
        end else begin
            m_addr_q <= '0;
            m_data_q <= '0;
        end
    end

    assign m_drpen_o   = m_en_q;
    assign m_drpwe_o   = m_we_q;
    assign m_drpaddr_o = m_addr_q;
    assign m_drpdi_o   = m_data_q;

endmodule

// File: design/drp_interconnect.sv
module drp_interconnect
    import drp_pkg::*;
(
    // board DRP_CLK and DRP_RESETN
    input  logic                   drp_clk_i,
    input  logic                   drp_resetn_i,

    ////////////////////////////////////////
    // slave ports, packed by port index
    ////////////////////////////////////////

    input  logic      [NUM_SI-1:0] s_drpen_i,
    input  logic      [NUM_SI-1:0] s_drpwe_i,
    input  drp_addr_t [NUM_SI-1:0] s_drpaddr_i,
    input  drp_data_t [NUM_SI-1:0] s_drpdi_i,
    output logic      [NUM_SI-1:0] s_drprdy_o,
    output drp_data_t [NUM_SI-1:0] s_drpdo_o,

    ////////////////////////////////////////
    // master port
    ////////////////////////////////////////

    output logic                   m_drpen_o,
    output logic                   m_drpwe_o,
    output drp_addr_t              m_drpaddr_o,
    output drp_data_t              m_drpdi_o,     // write data to target
    input  logic                   m_drprdy_i,
    input  drp_data_t              m_drpdo_i      // read data from target
);

    // one captured request per slave port
    drp_req_if req_if [NUM_SI] ();

    for (genvar g = 0; g < NUM_SI; g++) begin : g_slot
        drp_req_slot u_slot (
            .drp_clk_i    (drp_clk_i),
            .drp_resetn_i (drp_resetn_i),
            .drpen_i      (s_drpen_i[g]),
            .drpwe_i      (s_drpwe_i[g]),
            .drpaddr_i    (s_drpaddr_i[g]),
            .drpdi_i      (s_drpdi_i[g]),
            .req          (req_if[g])
        );
    end

    // drains the slots one at a time
    drp_arbiter u_arbiter (
        .drp_clk_i    (drp_clk_i),
        .drp_resetn_i (drp_resetn_i),
        .req          (req_if),
        .m_drpen_o    (m_drpen_o),
        .m_drpwe_o    (m_drpwe_o),
        .m_drpaddr_o  (m_drpaddr_o),
        .m_drpdi_o    (m_drpdi_o),
        .m_drprdy_i   (m_drprdy_i),
        .m_drpdo_i    (m_drpdo_i),
        .s_drprdy_o   (s_drprdy_o),
        .s_drpdo_o    (s_drpdo_o)
    );

endmodule

// File: tb/drp_target_model.sv
module drp_target_model
    import drp_pkg::*;
(
    input  logic      drp_clk_i,
    input  logic      drp_resetn_i,
    input  logic      drpen_i,
    input  logic      drpwe_i,
    input  drp_addr_t drpaddr_i,
    input  drp_data_t drpdi_i,
    output logic      drprdy_o,
    output drp_data_t drpdo_o
);

    timeunit 1ns;
    timeprecision 1ps;

    drp_data_t mem [4096];
    logic      busy;
    logic      we_q;
    drp_addr_t addr_q;
    drp_data_t data_q;
    int        wait_cnt;                          // cycles left before ready

    initial begin
        drprdy_o = 1'b0;
        drpdo_o  = '0;
    end

    // latency from enable to ready is 1 to 6 cycles
    always @(posedge drp_clk_i) begin
        if (!drp_resetn_i) begin
            for (int a = 0; a < 4096; a++) begin
                mem[a] <= drp_data_t'(a) ^ 16'hA5A5;
            end
            busy     <= 1'b0;
            wait_cnt <= 0;
            drprdy_o <= 1'b0;
            drpdo_o  <= '0;
        end else begin
            drprdy_o <= 1'b0;
            drpdo_o  <= '0;                       // data only valid with ready
            if (drpen_i) begin
                busy     <= 1'b1;
                we_q     <= drpwe_i;
                addr_q   <= drpaddr_i;
                data_q   <= drpdi_i;
                wait_cnt <= int'($urandom_range(0, 5));
            end else if (busy) begin
                if (wait_cnt == 0) begin
                    drprdy_o <= 1'b1;
                    busy     <= 1'b0;
                    if (we_q) begin
                        mem[addr_q] <= data_q;
                    end else begin
                        drpdo_o <= mem[addr_q];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

// File: tb/tb_drp_interconnect.sv
module tb_drp_interconnect
    import drp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          RESET_CYCLES = 8;
    localparam int          NUM_TRANS    = 200;   // random requests per port
    localparam int          MAX_CYCLES   = 20000;
    localparam logic [31:0] SEED         = 32'h8de0_df1e;

    logic                   DRP_CLK;
    logic                   DRP_RESETN;
    logic      [NUM_SI-1:0] s_drpen;
    logic      [NUM_SI-1:0] s_drpwe;
    drp_addr_t [NUM_SI-1:0] s_drpaddr;
    drp_data_t [NUM_SI-1:0] s_drpdi;
    logic      [NUM_SI-1:0] s_drprdy;
    drp_data_t [NUM_SI-1:0] s_drpdo;
    logic                   m_drpen;
    logic                   m_drpwe;
    drp_addr_t              m_drpaddr;
    drp_data_t              m_drpdi;
    logic                   m_drprdy;
    drp_data_t              m_drpdo;

    int        phase;
    int        phase_done [NUM_SI];
    int        cycle_cnt = 0;
    int        data_errs = 0;
    int        proto_errs = 0;
    int        seq_errs = 0;

    drp_data_t shadow [4096];
    drp_addr_t m_addr_log [$];                    // every address issued on the master port
    logic      [NUM_SI-1:0] out_pend;
    logic      [NUM_SI-1:0] out_we;
    drp_addr_t out_addr [NUM_SI];
    drp_data_t out_data [NUM_SI];
    logic      m_busy;

    drp_interconnect UUT (
        .drp_clk_i    (DRP_CLK),
        .drp_resetn_i (DRP_RESETN),
        .s_drpen_i    (s_drpen),
        .s_drpwe_i    (s_drpwe),
        .s_drpaddr_i  (s_drpaddr),
        .s_drpdi_i    (s_drpdi),
        .s_drprdy_o   (s_drprdy),
        .s_drpdo_o    (s_drpdo),
        .m_drpen_o    (m_drpen),
        .m_drpwe_o    (m_drpwe),
        .m_drpaddr_o  (m_drpaddr),
        .m_drpdi_o    (m_drpdi),
        .m_drprdy_i   (m_drprdy),
        .m_drpdo_i    (m_drpdo)
    );

    drp_target_model u_target (
        .drp_clk_i    (DRP_CLK),
        .drp_resetn_i (DRP_RESETN),
        .drpen_i      (m_drpen),
        .drpwe_i      (m_drpwe),
        .drpaddr_i    (m_drpaddr),
        .drpdi_i      (m_drpdi),
        .drprdy_o     (m_drprdy),
        .drpdo_o      (m_drpdo)
    );

    initial begin
        DRP_CLK = 1'b0;
        forever #5 DRP_CLK = ~DRP_CLK;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // power-up contents of the target
    function automatic drp_data_t fill_word(int a);
        return drp_data_t'(a) ^ 16'hA5A5;
    endfunction

    function automatic drp_data_t ref_read(drp_addr_t a);
        return shadow[a];
    endfunction

    // each port owns a 1K address window
    function automatic drp_addr_t port_base(int p);
        return drp_addr_t'(p * 1024);
    endfunction

    function automatic string test_name(int ph);
        case (ph)
            0:       return "reset";
            1:       return "write_read";
            2:       return "simultaneous";
            default: return "random";
        endcase
    endfunction

    ////////////////////////////////////////
    // per-port drivers
    ////////////////////////////////////////

    for (genvar g = 0; g < NUM_SI; g++) begin : g_drv
        logic      en;
        logic      we;
        drp_addr_t addr;
        drp_data_t di;
        int        done_phase;

        assign s_drpen[g]    = en;
        assign s_drpwe[g]    = we;
        assign s_drpaddr[g]  = addr;
        assign s_drpdi[g]    = di;
        assign phase_done[g] = done_phase;

        // one enable pulse, then hold off until this port's ready
        task automatic request(input logic w, input drp_addr_t a, input drp_data_t d);
            @(posedge DRP_CLK);
            en   <= 1'b1;
            we   <= w;
            addr <= a;
            di   <= d;
            @(posedge DRP_CLK);
            en <= 1'b0;
            do begin
                @(posedge DRP_CLK);
            end while (!s_drprdy[g]);
        endtask

        initial begin
            en         = 1'b0;
            we         = 1'b0;
            addr       = '0;
            di         = '0;
            done_phase = 0;

            wait (phase == 1);
            request(1'b1, port_base(g) + 12'h020, drp_data_t'(32'h1234 + g * 32'h1111));
            request(1'b0, port_base(g) + 12'h020, '0);
            request(1'b0, port_base(g) + 12'h021, '0);    // untouched word
            done_phase = 1;

            wait (phase == 2);
            request(1'b0, port_base(g) + 12'h010, '0);
            done_phase = 2;

            wait (phase == 3);
            for (int n = 0; n < NUM_TRANS; n++) begin
                repeat ($urandom_range(0, 4)) @(posedge DRP_CLK);
                request(1'($urandom_range(0, 1)),
                        port_base(g) + drp_addr_t'($urandom_range(0, 63)),
                        drp_data_t'($urandom));
            end
            done_phase = 3;
        end
    end

    ////////////////////////////////////////
    // response and protocol checks
    ////////////////////////////////////////

    always @(posedge DRP_CLK) begin : compare
        drp_data_t exp_val;

        if (!DRP_RESETN) begin
            for (int a = 0; a < 4096; a++) begin
                shadow[a] = fill_word(a);
            end
            out_pend = '0;
            m_busy   = 1'b0;
        end else begin
            if ($countones(s_drprdy) > 1) begin
                proto_errs++;
                $display("more than one slave port ready in one cycle: %b", s_drprdy);
            end
            for (int p = 0; p < NUM_SI; p++) begin
                if (s_drprdy[p]) begin
                    if (!out_pend[p]) begin
                        proto_errs++;
                        $display("port %0d got a ready with no request outstanding", p);
                    end else if (!out_we[p]) begin
                        exp_val = ref_read(out_addr[p]);
                        if (s_drpdo[p] != exp_val) begin
                            data_errs++;
                            $display("ERR %s port %0d addr %h: expected %h, actual %h",
                                     test_name(phase), p, out_addr[p], exp_val, s_drpdo[p]);
                        end
                    end else begin
                        shadow[out_addr[p]] = out_data[p];
                    end
                    out_pend[p] = 1'b0;
                end else if (s_drpdo[p] != '0) begin
                    data_errs++;
                    $display("ERR %s port %0d idle read data: expected %h, actual %h",
                             test_name(phase), p, 16'h0000, s_drpdo[p]);
                end
                if (s_drpen[p]) begin
                    out_pend[p] = 1'b1;
                    out_we[p]   = s_drpwe[p];
                    out_addr[p] = s_drpaddr[p];
                    out_data[p] = s_drpdi[p];
                end
            end

            // master side carries one transaction at a time
            if (m_drprdy) begin
                m_busy = 1'b0;
            end
            if (m_drpen) begin
                if (m_busy) begin
                    proto_errs++;
                    $display("master enable issued while a transaction was outstanding");
                end
                m_busy = 1'b1;
                m_addr_log.push_back(m_drpaddr);
            end
        end
    end

    always @(posedge DRP_CLK) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    task automatic wait_ports_done(input int ph);
        for (int p = 0; p < NUM_SI; p++) begin
            wait (phase_done[p] == ph);
        end
    endtask

    // grants must follow port priority
    task automatic check_grant_order(input int base);
        drp_addr_t exp_addr;

        if (m_addr_log.size() < base + NUM_SI) begin
            seq_errs++;
            $display("simultaneous test issued only %0d master transactions",
                     m_addr_log.size() - base);
        end else begin
            for (int p = 0; p < NUM_SI; p++) begin
                exp_addr = port_base(p) + 12'h010;
                if (m_addr_log[base + p] != exp_addr) begin
                    seq_errs++;
                    $display("ERR %s grant %0d: expected %h, actual %h",
                             test_name(2), p, exp_addr, m_addr_log[base + p]);
                end
            end
        end
    endtask

    initial begin
        int base;

        void'($urandom(SEED));
        DRP_RESETN = 1'b0;
        phase      = 0;
        repeat (RESET_CYCLES) @(posedge DRP_CLK);
        DRP_RESETN <= 1'b1;

        // nothing may move before the first request
        repeat (5) begin
            @(posedge DRP_CLK);
            if (m_drpen !== 1'b0) begin
                seq_errs++;
                $display("ERR reset m_drpen: expected %b, actual %b", 1'b0, m_drpen);
            end
            if (s_drprdy !== '0) begin
                seq_errs++;
                $display("ERR reset s_drprdy: expected %b, actual %b", 3'b000, s_drprdy);
            end
        end

        phase = 1;
        wait_ports_done(1);
        @(posedge DRP_CLK);
        base  = m_addr_log.size();
        phase = 2;
        wait_ports_done(2);
        check_grant_order(base);
        @(posedge DRP_CLK);
        phase = 3;
        wait_ports_done(3);
        repeat (4) @(posedge DRP_CLK);

        $display("errors: data %0d, protocol %0d, sequence %0d",
                 data_errs, proto_errs, seq_errs);
        if (data_errs == 0 && proto_errs == 0 && seq_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: drp_interconnect.f
design/drp_pkg.sv
design/drp_req_if.sv
design/drp_req_slot.sv
design/drp_arbiter.sv
design/drp_interconnect.sv
tb/drp_target_model.sv
tb/tb_drp_interconnect.sv

// File: run.sh
#!/bin/sh
# build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f drp_interconnect.f \
    --top-module tb_drp_interconnect -Mdir obj_dir -o sim_drp
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_drp)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1
